// File: list.f
common/rv_pkg.sv
decode/rv_decoder.sv
decode/imm_gen.sv
design/alu.sv
design/reg_file.sv
design/rv_core.sv
bench/tb_mem_model.sv
bench/tb_rv_core.sv

// File: bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int max_instr    = 200;            // upper bound on instrs executed per run
    localparam int worst_cycles = 14;             // fetch, ex, mem, wb with 3 waits each
    localparam int timeout_ns   = 2 * (max_instr * worst_cycles + 20) * 4;
    localparam logic [31:0] data_base = 32'h400;  // store area
    localparam logic [31:0] va = 32'h9000_0123;   // x1 is negative
    localparam logic [31:0] vb = 32'h0000_0007;   // x2

    logic            clk;
    logic            reset_n;
    mem_req_t        mem_req;
    logic            mem_ready;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] peek;

    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_tid [$];
    logic [31:0] run1_addr [$];
    logic [31:0] run1_data [$];
    logic [31:0] end_pc, jal_pc, jalr_pc, jalr_tgt;
    int          st_off;
    int          checks [1:6];
    int          errors [1:6];
    string       names [1:6] = '{"reset and request rules", "alu operations",
                                 "lui auipc load store", "branches", "jumps", "back-pressure"};
    logic [2:0]  f3_tab [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    logic [6:0]  f7_tab [10] = '{0, 7'h20, 0, 0, 0, 0, 0, 7'h20, 0, 0};

    rv_core u_dut (.clk(clk), .reset_n(reset_n), .mem_req(mem_req),
                   .mem_ready(mem_ready), .mem_rdata(mem_rdata), .peek(peek));

    tb_mem_model u_mem (.clk(clk), .mem_req(mem_req), .mem_ready(mem_ready),
                        .mem_rdata(mem_rdata));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // port rules
    // ----------------------------------------------------------------------
    first_req: assert property (@(posedge clk) $rose(reset_n) |->
            mem_req.valid && mem_req.instr && mem_req.addr == 32'h0) checks[1]++;
        else begin
            errors[1]++;
            $display("Fail mem_req.addr expected 00000000 got %h", mem_req.addr);
        end
    hold_req: assert property (@(posedge clk) disable iff (!reset_n)
            mem_req.valid && !mem_ready |=> $stable(mem_req)) checks[1]++;
        else begin
            errors[1]++;
            $display("request changed while mem_ready was low");
        end
    strobe: assert property (@(posedge clk) disable iff (!reset_n)
            (mem_req.wstrb == 4'h0 && mem_req.wdata == '0) ||
            (mem_req.wstrb == 4'hf && mem_req.valid && !mem_req.instr)) checks[1]++;
        else begin
            errors[1]++;
            $display("Fail mem_req.wstrb expected 0 or f got %h", mem_req.wstrb);
        end

    // ----------------------------------------------------------------------
    // rv32i reference and encoders
    // ----------------------------------------------------------------------
    function automatic logic [31:0] ref_alu(int k, logic [31:0] x, logic [31:0] y);
        case (k)
            0:       return x + y;
            1:       return x - y;
            2:       return x << y[4:0];
            3:       return {31'b0, $signed(x) < $signed(y)};
            4:       return {31'b0, x < y};
            5:       return x ^ y;
            6:       return x >> y[4:0];
            7:       return $signed(x) >>> y[4:0];
            8:       return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic br_taken(logic [2:0] f3, logic [31:0] x, logic [31:0] y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(logic [31:0] w);
        prog.push_back(w);
    endtask

    // sw rs, st_off(x10) and its expected log entry
    task automatic store_reg(logic [4:0] rs, logic [31:0] val, int tid, logic keep);
        logic [11:0] off;
        off = st_off[11:0];
        emit({off[11:5], rs, 5'd10, 3'b010, off[4:0], 7'b0100011});
        if (keep) begin
            exp_addr.push_back(data_base + st_off);
            exp_data.push_back(val);
            exp_tid.push_back(tid);
        end
        st_off += 4;
    endtask

    task automatic build_program();
        logic [31:0] y;
        logic [31:0] regv [3];
        logic [11:0] imm12;
        logic [31:0] here;
        regv = '{0, va, vb};
        st_off = 0;
        emit({20'h90000, 5'd1, 7'b0110111});          // lui x1
        emit(enc_i(12'h123, 1, 0, 1, 7'b0010011));    // x1 = va
        emit(enc_i(12'd7, 0, 0, 2, 7'b0010011));      // x2 = vb
        emit(enc_i(12'h400, 0, 0, 10, 7'b0010011));   // store base
        for (int k = 0; k < 10; k++) begin             // register forms
            emit({f7_tab[k], 5'd2, 5'd1, f3_tab[k], 5'd3, 7'b0110011});
            store_reg(3, ref_alu(k, va, vb), 2, 1'b1);
        end
        for (int k = 0; k < 10; k++) begin             // immediate forms have no subi
            if (k == 1)
                continue;
            imm12 = (k == 2 || k == 6) ? 12'd4 : (k == 7) ? {7'h20, 5'd4} : 12'hffb;
            y     = (k == 2 || k == 6 || k == 7) ? 32'd4 : 32'hffff_fffb;
            emit(enc_i(imm12, 1, f3_tab[k], 3, 7'b0010011));
            store_reg(3, ref_alu(k, va, y), 2, 1'b1);
        end
        emit({20'hABCDE, 5'd4, 7'b0110111});
        store_reg(4, 32'hABCD_E000, 3, 1'b1);
        here = prog.size() * 4;
        emit({20'h12345, 5'd5, 7'b0010111});          // auipc x5
        store_reg(5, here + 32'h1234_5000, 3, 1'b1);
        emit(enc_i(12'h100, 10, 3'b010, 6, 7'b0000011));  // lw x6 from the preloaded word
        store_reg(6, 32'hCAFE_F00D, 3, 1'b1);
        emit(enc_i(12'h055, 0, 0, 0, 7'b0010011));    // write to x0
        store_reg(0, 32'h0, 3, 1'b1);
        // each branch skips its marker store when taken
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            for (int p = 0; p < 3; p++) begin
                logic [4:0] r1, r2;
                r1 = (p == 0) ? 5'd1 : 5'd2;
                r2 = (p == 1) ? 5'd1 : 5'd2;
                emit(enc_b(13'd12, r2, r1, f[2:0]));
                emit(enc_i(12'h040 + f * 3 + p, 0, 0, 7, 7'b0010011));
                store_reg(7, 32'h40 + f * 3 + p, 4, !br_taken(f[2:0], regv[r1], regv[r2]));
            end
        end
        jal_pc = prog.size() * 4;
        emit(enc_j(21'd8, 11));                        // jal x11, +8
        emit(enc_i(12'd99, 0, 0, 12, 7'b0010011));    // skipped
        store_reg(11, jal_pc + 4, 5, 1'b1);
        store_reg(12, 32'h0, 5, 1'b1);
        jalr_pc  = prog.size() * 4 + 4;
        jalr_tgt = jalr_pc + 8;
        emit(enc_i(jalr_tgt[11:0] + 12'd1, 0, 0, 13, 7'b0010011));  // odd target
        emit(enc_i(12'd0, 13, 0, 14, 7'b1100111));    // jalr x14, 0(x13)
        emit(enc_i(12'd77, 0, 0, 12, 7'b0010011));    // skipped
        store_reg(14, jalr_pc + 4, 5, 1'b1);
        store_reg(12, 32'h0, 5, 1'b1);
        end_pc = prog.size() * 4;
        emit(enc_j(21'd0, 0));                         // park here
    endtask

    // ----------------------------------------------------------------------
    // run control and checks
    // ----------------------------------------------------------------------
    task automatic run_program(logic with_wait);
        reset_n = 1'b0;
        u_mem.waits.delete();
        if (with_wait)
            for (int i = 0; i < 4000; i++)
                u_mem.waits.push_back($urandom_range(3, 0));
        for (int i = 0; i < 512; i++)
            u_mem.mem[i] = 32'h5A5A_0000 ^ (i * 4);    // address-dependent fill
        foreach (prog[i])
            u_mem.mem[i] = prog[i];
        u_mem.mem[32'h500 >> 2] = 32'hCAFE_F00D;
        u_mem.log_addr.delete();
        u_mem.log_data.delete();
        u_mem.fetch_addr.delete();
        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;
        while (peek !== end_pc) begin
            @(posedge clk);
            #1;                                        // pc settled after the edge
        end
    endtask

    task automatic check_val(string name, int tid, logic [31:0] exp, logic [31:0] got);
        checks[tid]++;
        value_ok: assert (exp === got)
            else begin
                errors[tid]++;
                $display("Fail %s expected %h got %h", name, exp, got);
            end
    endtask

    task automatic check_next_fetch(int tid, logic [31:0] from, logic [31:0] exp);
        int idx;
        idx = -1;
        foreach (u_mem.fetch_addr[i])
            if (idx < 0 && u_mem.fetch_addr[i] == from)
                idx = i;
        if (idx < 0 || idx + 1 >= u_mem.fetch_addr.size()) begin
            errors[tid]++;
            $display("jump instruction was never fetched or had no following fetch");
        end else begin
            check_val("next fetch addr", tid, exp, u_mem.fetch_addr[idx + 1]);
        end
    endtask

    task automatic report(int tid);
        $display("test %0d %s: %0d checks, %0d errors", tid, names[tid], checks[tid],
                 errors[tid]);
    endtask

    initial begin
        int total_err;
        int total_chk;
        reset_n = 1'b0;
        void'($urandom(32'h555f));
        for (int t = 1; t <= 6; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        build_program();
        run_program(1'b0);
        if (u_mem.log_data.size() != exp_data.size()) begin
            errors[2]++;
            $display("store log length differs from the expected store count");
        end else begin
            foreach (exp_data[i]) begin
                check_val("store addr", exp_tid[i], exp_addr[i], u_mem.log_addr[i]);
                check_val("store data", exp_tid[i], exp_data[i], u_mem.log_data[i]);
            end
        end
        check_next_fetch(5, jal_pc, jal_pc + 8);
        check_next_fetch(5, jalr_pc, jalr_tgt);
        for (int t = 2; t <= 5; t++)
            report(t);
        run1_addr = u_mem.log_addr;
        run1_data = u_mem.log_data;
        run_program(1'b1);                               // same program with wait states
        if (u_mem.log_data.size() != run1_data.size()) begin
            errors[6]++;
            $display("store log with wait states has a different length");
        end else begin
            foreach (run1_data[i]) begin
                check_val("store addr", 6, run1_addr[i], u_mem.log_addr[i]);
                check_val("store data", 6, run1_data[i], u_mem.log_data[i]);
            end
        end
        report(6);
        report(1);
        total_err = 0;
        total_chk = 0;
        for (int t = 1; t <= 6; t++) begin
            total_err += errors[t];
            total_chk += checks[t];
        end
        $display("totals: %0d checks, %0d errors", total_chk, total_err);
        if (total_err == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // watchdog over both runs
    initial begin
        #(timeout_ns * 1ns);
        $display("watchdog expired before the program reached its final loop");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: bench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                    clk,
    input  rv_pkg::mem_req_t        mem_req,
    output logic                    mem_ready,
    output logic [rv_pkg::xlen-1:0] mem_rdata
);
    import rv_pkg::*;

    logic [xlen-1:0] mem [512];         // 2 KB, word indexed
    logic [xlen-1:0] log_addr [$];      // store log
    logic [xlen-1:0] log_data [$];
    logic [xlen-1:0] fetch_addr [$];    // every accepted fetch
    int unsigned     waits [$];         // wait cycles, filled by the bench
    int unsigned     wait_cnt;
    logic            xfer;

    assign mem_rdata = mem[mem_req.addr[10:2]];

    initial begin
        mem_ready = 1'b0;
        xfer      = 1'b0;
        wait_cnt  = 0;
    end

    // sample at negedge, request and ready are settled here
    always @(negedge clk) begin
        xfer = mem_req.valid && mem_ready;
        if (xfer && mem_req.instr)
            fetch_addr.push_back(mem_req.addr);
        if (xfer && mem_req.wstrb != 4'h0) begin
            mem[mem_req.addr[10:2]] = mem_req.wdata;
            log_addr.push_back(mem_req.addr);
            log_data.push_back(mem_req.wdata);
        end
    end

    // ready changes 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        if (xfer) begin
            mem_ready <= 1'b0;
            wait_cnt = (waits.size() > 0) ? waits.pop_front() : 0;  // next gap
        end else if (mem_req.valid) begin
            if (wait_cnt == 0)
                mem_ready <= 1'b1;
            else
                wait_cnt--;
        end
    end

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset_n,
    output rv_pkg::mem_req_t        mem_req,
    input  logic                    mem_ready,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    output logic [rv_pkg::xlen-1:0] peek
);
    import rv_pkg::*;

    stage_t          stage;
    stage_t          stage_next;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus_step;
    logic [xlen-1:0] instr_reg;   // fetched instruction
    logic [xlen-1:0] load_data;   // lw result
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_in1;
    logic [xlen-1:0] alu_in2;
    logic [xlen-1:0] alu_result;
    logic            branch_taken;
    logic            rf_we;
    logic [xlen-1:0] rf_wdata;

    assign peek         = pc;
    assign pc_plus_step = pc + instr_step;

    // ----------------------------------------------------------------------
    // decode, datapath
    // ----------------------------------------------------------------------
    rv_decoder u_decoder (.instr(instr_reg), .ctrl(ctrl));

    imm_gen u_imm_gen (.instr(instr_reg), .imm(imm));

    always_comb begin
        case (ctrl.in1_sel)
            in1_rs1: alu_in1 = rs1_data;
            in1_pc:  alu_in1 = pc;        // auipc
            default: alu_in1 = '0;        // lui
        endcase
    end
    assign alu_in2 = ctrl.in2_rs2 ? rs2_data : imm;

    alu u_alu (
        .in1          (alu_in1),
        .in2          (alu_in2),
        .op           (ctrl.alu_op),
        .cmp1         (rs1_data),
        .cmp2         (rs2_data),
        .funct3       (instr_reg[14:12]),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    // write-back value and strobe
    assign rf_we    = (stage == wb_stage) && ctrl.reg_write;
    assign rf_wdata = ctrl.mem_to_reg ? load_data    :
                      ctrl.jump       ? pc_plus_step :  // link
                                        alu_result;

    reg_file u_reg_file (
        .clk     (clk),
        .reset_n (reset_n),
        .we      (rf_we),
        .rs1     (instr_reg[19:15]),
        .rs2     (instr_reg[24:20]),
        .rd      (instr_reg[11:7]),
        .wdata   (rf_wdata),
        .rdata1  (rs1_data),
        .rdata2  (rs2_data)
    );

    // ----------------------------------------------------------------------
    // memory request
    // ----------------------------------------------------------------------
    always_comb begin
        mem_req = '0;  // idle in ex / wb
        case (stage)
            if_stage: begin
                mem_req.valid = 1'b1;
                mem_req.instr = 1'b1;
                mem_req.addr  = pc;
            end
            mem_stage: begin
                mem_req.valid = 1'b1;
                mem_req.addr  = alu_result;  // rs1 + imm, stable while waiting
                if (ctrl.mem_write) begin
                    mem_req.wdata = rs2_data;
                    mem_req.wstrb = 4'hf;
                end
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------------------
    // stage sequencer
    // ----------------------------------------------------------------------
    always_comb begin
        stage_next = stage;
        case (stage)
            if_stage:  if (mem_ready) stage_next = ex_stage;
            ex_stage:  stage_next = (ctrl.mem_write || ctrl.mem_to_reg) ? mem_stage : wb_stage;
            mem_stage: if (mem_ready) stage_next = wb_stage;
            default:   stage_next = if_stage;  // wb
        endcase
    end

    // next pc, taken only in wb
    always_comb begin
        if (ctrl.branch && branch_taken)
            pc_next = pc + imm;
        else if (ctrl.jump_reg)
            pc_next = {alu_result[xlen-1:1], 1'b0};  // jalr clears bit 0
        else if (ctrl.jump)
            pc_next = pc + imm;
        else
            pc_next = pc_plus_step;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage     <= if_stage;
            pc        <= reset_pc;
            instr_reg <= '0;
        end else begin
            stage <= stage_next;
            if (stage == if_stage && mem_ready)
                instr_reg <= mem_rdata;
            if (stage == wb_stage)
                pc <= pc_next;
        end
    end

    // load data capture
    always_ff @(posedge clk) begin
        if (stage == mem_stage && mem_ready && ctrl.mem_to_reg)
            load_data <= mem_rdata;
    end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1 << reg_addr_w];

    // x0 is hardwired to zero on read
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < (1 << reg_addr_w); i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[rd] <= wdata;  // x0 write lands but never reads back
        end
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::xlen-1:0] in1,
    input  logic [rv_pkg::xlen-1:0] in2,
    input  rv_pkg::alu_op_t         op,
    input  logic [rv_pkg::xlen-1:0] cmp1,
    input  logic [rv_pkg::xlen-1:0] cmp2,
    input  logic [2:0]              funct3,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = in2[4:0];  // rv32 shifts use low five bits

    // ----------------------------------------------------------------------
    // arithmetic / logic
    // ----------------------------------------------------------------------
    always_comb begin
        case (op)
            alu_add:  result = in1 + in2;
            alu_sub:  result = in1 - in2;
            alu_sll:  result = in1 << shamt;
            alu_slt:  result = {31'b0, $signed(in1) < $signed(in2)};
            alu_sltu: result = {31'b0, in1 < in2};
            alu_xor:  result = in1 ^ in2;
            alu_srl:  result = in1 >> shamt;
            alu_sra:  result = $signed(in1) >>> shamt;  // sign fill
            alu_or:   result = in1 | in2;
            alu_and:  result = in1 & in2;
            default:  result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // branch condition on rs1 / rs2
    // ----------------------------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (cmp1 == cmp2);                    // beq
            3'b001:  branch_taken = (cmp1 != cmp2);                    // bne
            3'b100:  branch_taken = ($signed(cmp1) <  $signed(cmp2));  // blt
            3'b101:  branch_taken = ($signed(cmp1) >= $signed(cmp2));  // bge
            3'b110:  branch_taken = (cmp1 <  cmp2);                    // bltu
            3'b111:  branch_taken = (cmp1 >= cmp2);                    // bgeu
            default: branch_taken = 1'b0;  // 010 / 011 reserved
        endcase
    end

endmodule

// File: decode/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] imm
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        case (opcode)
            op_lui, op_auipc:                           // U
                imm = {instr[31:12], 12'b0};
            op_store:                                   // S
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch:                                  // B, bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            op_jal:                                     // J
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            op_imm:
                if (funct3 == 3'b001 || funct3 == 3'b101)
                    imm = {27'b0, instr[24:20]};        // shamt only
                else
                    imm = {{20{instr[31]}}, instr[31:20]};
            default:                                    // I: lw, jalr
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// File: decode/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0] instr,
    output rv_pkg::ctrl_t           ctrl
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    imm_op;  // op_imm flavour
    alu_op_t    reg_op;  // op_reg flavour

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ----------------------------------------------------------------------
    // alu operation select
    // ----------------------------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  imm_op = alu_add;
            3'b001:  imm_op = alu_sll;
            3'b010:  imm_op = alu_slt;
            3'b011:  imm_op = alu_sltu;
            3'b100:  imm_op = alu_xor;
            3'b101:  imm_op = (funct7 == 7'h20) ? alu_sra : alu_srl;  // srai vs srli
            3'b110:  imm_op = alu_or;
            default: imm_op = alu_and;
        endcase
    end

    // register form, funct7 picks sub / sra
    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: reg_op = alu_add;
            10'b0100000_000: reg_op = alu_sub;
            10'b0000000_001: reg_op = alu_sll;
            10'b0000000_010: reg_op = alu_slt;
            10'b0000000_011: reg_op = alu_sltu;
            10'b0000000_100: reg_op = alu_xor;
            10'b0000000_101: reg_op = alu_srl;
            10'b0100000_101: reg_op = alu_sra;
            10'b0000000_110: reg_op = alu_or;
            10'b0000000_111: reg_op = alu_and;
            default:         reg_op = alu_add;  // unknown encoding
        endcase
    end

    // ----------------------------------------------------------------------
    // control flags per opcode
    // ----------------------------------------------------------------------
    always_comb begin
        ctrl         = '0;       // unknown opcode acts as nop
        ctrl.in1_sel = in1_rs1;
        ctrl.alu_op  = alu_add;  // address and jump forms
        case (opcode)
            op_load: begin
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            op_store: ctrl.mem_write = 1'b1;  // addr = rs1 + imm
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = imm_op;
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.in2_rs2   = 1'b1;
                ctrl.alu_op    = reg_op;
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.in1_sel   = in1_zero;  // 0 + imm
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.in1_sel   = in1_pc;    // pc + imm
            end
            op_branch: begin
                ctrl.branch  = 1'b1;
                ctrl.in2_rs2 = 1'b1;
                ctrl.alu_op  = alu_sub;
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
            end
            op_jalr: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jump_reg  = 1'b1;  // target rs1 + imm
            end
            default: ;
        endcase
    end

endmodule

// File: common/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------------------------------------
    // widths and constants
    // ----------------------------------------------------------------------
    localparam int xlen       = 32;                      // data / address width
    localparam int reg_addr_w = 5;                       // 32 integer regs
    localparam logic [xlen-1:0] instr_step = 32'd4;      // one word per instr
    localparam logic [xlen-1:0] reset_pc   = 32'h0000_0000;

    // ----------------------------------------------------------------------
    // encodings
    // ----------------------------------------------------------------------
    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,  // lw
        op_store  = 7'b0100011,  // sw
        op_imm    = 7'b0010011,  // addi, slli, ...
        op_reg    = 7'b0110011,  // add, sub, ...
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_branch = 7'b1100011,  // beq .. bgeu
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_sll  = 4'b0010,
        alu_slt  = 4'b0011,
        alu_sltu = 4'b0100,
        alu_xor  = 4'b0101,
        alu_srl  = 4'b0110,
        alu_sra  = 4'b0111,
        alu_or   = 4'b1000,
        alu_and  = 4'b1001
    } alu_op_t;

    // alu operand 1 source
    typedef enum logic [1:0] {
        in1_zero = 2'd0,  // lui
        in1_rs1  = 2'd1,  // most instructions
        in1_pc   = 2'd2   // auipc
    } alu_in1_sel_t;

    typedef enum logic [1:0] {
        if_stage,
        ex_stage,
        mem_stage,
        wb_stage
    } stage_t;

    // ----------------------------------------------------------------------
    // bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic         mem_write;   // sw
        logic         mem_to_reg;  // lw, wb takes load data
        logic         reg_write;
        logic         branch;
        logic         jump;        // jal and jalr, wb takes pc + 4
        logic         jump_reg;    // jalr only
        alu_in1_sel_t in1_sel;
        logic         in2_rs2;     // 0 selects the immediate
        alu_op_t      alu_op;
    } ctrl_t;

    // native memory request, 70 bits
    typedef struct packed {
        logic            valid;
        logic            instr;  // fetch
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [3:0]      wstrb;  // 4'hf on store, else 0
    } mem_req_t;

endpackage
